//--- verilog/cpu_types_pkg.sv
// width typedefs, alu codes, pipeline and apb structs, memory-stage state enum
`default_nettype none

package cpu_types_pkg;

    // widths with a meaning
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm_t;
    typedef logic [3:0]  alu_op_t;

    // alu operation codes
    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_XOR = 4'd4;
    localparam alu_op_t ALU_NOR = 4'd5;
    localparam alu_op_t ALU_SLT = 4'd6;
    localparam alu_op_t ALU_SLL = 4'd7;
    localparam alu_op_t ALU_SRL = 4'd8;
    localparam alu_op_t ALU_LUI = 4'd9;

    // data memory depth in words
    localparam int DMEM_WORDS = 256;

    // link register for jal
    localparam reg_addr_t LINK_REG = 5'd31;

    // decoded op from the decode stage
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     rdat1;
        word_t     rdat2;
        imm_t      imm;
        shamt_t    shamt;
        alu_op_t   alu_op;
        logic      alu_src_imm;
        logic      sign_ext;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        reg_addr_t wsel;
        logic      branch_eq;
        logic      branch_ne;
        logic      jump;
        logic      jump_reg;
        logic      jal;
        logic      halt;
    } ex_op_t;

    // execute/memory register contents
    typedef struct packed {
        logic      valid;
        word_t     alu_result;
        word_t     store_data;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        reg_addr_t wsel;
        logic      redirect_valid;
        word_t     redirect_target;
        logic      halt;
    } ex_mem_t;

    // writeback record
    typedef struct packed {
        logic      valid;
        logic      reg_write;
        reg_addr_t wsel;
        word_t     wdata;
    } wb_t;

    // taken branch or jump, to fetch
    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    // apb master to slave
    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        word_t paddr;
        word_t pwdata;
    } apb_req_t;

    // apb slave to master
    typedef struct packed {
        logic  pready;
        word_t prdata;
        logic  pslverr;
    } apb_rsp_t;

    // memory stage fsm
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } mem_state_t;

endpackage

`default_nettype wire

//--- verilog/alu.sv
// combinational alu with add, sub, logic ops, slt, shifts and lui
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpu_types_pkg::alu_op_t op,
    input  cpu_types_pkg::word_t   a,
    input  cpu_types_pkg::word_t   b,
    input  cpu_types_pkg::shamt_t  shamt,
    output cpu_types_pkg::word_t   result,
    output logic                   zero
);

    // difference shared by sub and the branch compare
    cpu_types_pkg::word_t diff;

    assign diff = a - b;

    // zero flag always from a - b, branches look at it
    assign zero = (diff == '0);

    always_comb begin
        case (op)
            cpu_types_pkg::ALU_ADD: begin
                result = a + b;
            end
            cpu_types_pkg::ALU_SUB: begin
                result = diff;
            end
            cpu_types_pkg::ALU_AND: begin
                result = a & b;
            end
            cpu_types_pkg::ALU_OR: begin
                result = a | b;
            end
            cpu_types_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            cpu_types_pkg::ALU_NOR: begin
                result = ~(a | b);
            end
            cpu_types_pkg::ALU_SLT: begin
                // signed compare
                result = {31'b0, ($signed(a) < $signed(b))};
            end
            cpu_types_pkg::ALU_SLL: begin
                // shifts act on b, as for mips sll/srl on rt
                result = b << shamt;
            end
            cpu_types_pkg::ALU_SRL: begin
                result = b >> shamt;
            end
            cpu_types_pkg::ALU_LUI: begin
                // low half of b into the upper half
                result = {b[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
// execute stage: operand select, alu, branch and jump target resolution
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  cpu_types_pkg::ex_op_t  op_in,
    output cpu_types_pkg::ex_mem_t ex_out
);

    cpu_types_pkg::word_t ext_imm;
    cpu_types_pkg::word_t alu_b;
    cpu_types_pkg::word_t alu_res;
    cpu_types_pkg::word_t pc_plus4;
    cpu_types_pkg::word_t pc_plus8;
    cpu_types_pkg::word_t br_target;
    cpu_types_pkg::word_t j_target;
    logic                 zero;
    logic                 br_taken;
    logic                 jumping;

    // immediate extension, sign or zero per decode
    assign ext_imm = op_in.sign_ext ? {{16{op_in.imm[15]}}, op_in.imm}
                                    : {16'h0000, op_in.imm};

    // second operand
    assign alu_b = op_in.alu_src_imm ? ext_imm : op_in.rdat2;

    alu u_alu (
        .op     (op_in.alu_op),
        .a      (op_in.rdat1),
        .b      (alu_b),
        .shamt  (op_in.shamt),
        .result (alu_res),
        .zero   (zero)
    );

    assign pc_plus4 = op_in.pc + 32'd4;
    // return address for jal
    assign pc_plus8 = pc_plus4 + 32'd4;

    // branch offset always sign extended, word aligned
    assign br_target = pc_plus4 + {{14{op_in.imm[15]}}, op_in.imm, 2'b00};

    // jump field is the immediate zero extended to 26 bits
    assign j_target = {pc_plus4[31:28], 10'b0, op_in.imm, 2'b00};

    assign br_taken = (op_in.branch_eq && zero) || (op_in.branch_ne && !zero);
    assign jumping  = op_in.jump || op_in.jal || op_in.jump_reg;

    always_comb begin
        ex_out.valid      = op_in.valid;
        ex_out.alu_result = op_in.jal ? pc_plus8 : alu_res;
        ex_out.store_data = op_in.rdat2;
        // control bits only ride with a valid op
        ex_out.mem_read   = op_in.valid && op_in.mem_read;
        ex_out.mem_write  = op_in.valid && op_in.mem_write;
        ex_out.reg_write  = op_in.valid && (op_in.reg_write || op_in.jal);
        ex_out.wsel       = op_in.jal ? cpu_types_pkg::LINK_REG : op_in.wsel;
        ex_out.halt       = op_in.valid && op_in.halt;

        ex_out.redirect_valid = op_in.valid && (br_taken || jumping);
        // jr wins, then j/jal, else branch
        if (op_in.jump_reg) begin
            ex_out.redirect_target = op_in.rdat1;
        end else if (op_in.jump || op_in.jal) begin
            ex_out.redirect_target = j_target;
        end else begin
            ex_out.redirect_target = br_target;
        end
    end

endmodule

`default_nettype wire

//--- verilog/exec_mem.sv
// execute/memory pipeline register with reset clear and stall hold
`timescale 1ns/1ps
`default_nettype none

module exec_mem (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   hold,
    input  cpu_types_pkg::ex_mem_t d,
    output cpu_types_pkg::ex_mem_t q
);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // empty slot, no control bits set
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
        // hold keeps the memory op in place for the whole transfer
    end

    // slot contents must be known once out of reset
    assert property (@(posedge CLK) disable iff (!nRST)
        !$isunknown(q.valid))
        else $error("exec_mem: q.valid unknown");

    // decode never sends a load that is also a store
    assert property (@(posedge CLK) disable iff (!nRST)
        !(q.mem_read && q.mem_write))
        else $error("exec_mem: mem_read and mem_write both set");

endmodule

`default_nettype wire

//--- verilog/mem_access.sv
// memory stage: apb master fsm, stall generation, writeback latch, halt and error flags
`timescale 1ns/1ps
`default_nettype none

module mem_access (
    input  logic                    CLK,
    input  logic                    nRST,
    input  cpu_types_pkg::ex_mem_t  em,
    output cpu_types_pkg::apb_req_t apb_req,
    input  cpu_types_pkg::apb_rsp_t apb_rsp,
    output logic                    stall,
    output cpu_types_pkg::wb_t      wb,
    output logic                    halted,
    output logic                    mem_err
);

    cpu_types_pkg::mem_state_t state;
    cpu_types_pkg::mem_state_t state_n;
    cpu_types_pkg::word_t      wdata_n;
    logic                      mem_op;
    logic                      done;
    logic                      bad_addr;
    logic                      xfer_err;

    // load or store sitting in the pipeline register
    assign mem_op = em.valid && (em.mem_read || em.mem_write);

    // transfer ends on pready in access
    assign done = (state == cpu_types_pkg::ACCESS) && apb_rsp.pready;

    // word index past the end of data memory
    assign bad_addr = em.alu_result[31:2] >= 30'(cpu_types_pkg::DMEM_WORDS);
    // only meaningful together with done
    assign xfer_err = apb_rsp.pslverr || bad_addr;

    // freeze upstream until the transfer completes
    assign stall = mem_op && !done;

    always_comb begin
        state_n = state;
        case (state)
            cpu_types_pkg::IDLE: begin
                if (mem_op) begin
                    state_n = cpu_types_pkg::SETUP;
                end
            end
            cpu_types_pkg::SETUP: begin
                // setup is always one cycle
                state_n = cpu_types_pkg::ACCESS;
            end
            cpu_types_pkg::ACCESS: begin
                if (apb_rsp.pready) begin
                    state_n = cpu_types_pkg::IDLE;
                end
            end
            default: begin
                state_n = cpu_types_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= cpu_types_pkg::IDLE;
        end else begin
            state <= state_n;
        end
    end

    // bus phase from state, address and data straight from the held slot
    assign apb_req.psel    = (state == cpu_types_pkg::SETUP) ||
                             (state == cpu_types_pkg::ACCESS);
    assign apb_req.penable = (state == cpu_types_pkg::ACCESS);
    assign apb_req.pwrite  = em.mem_write;
    assign apb_req.paddr   = em.alu_result;
    assign apb_req.pwdata  = em.store_data;

    // loaded word, zero on a failed load
    always_comb begin
        if (em.mem_read) begin
            wdata_n = xfer_err ? '0 : apb_rsp.prdata;
        end else begin
            wdata_n = em.alu_result;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wb      <= '0;
            halted  <= 1'b0;
            mem_err <= 1'b0;
        end else begin
            if (!stall) begin
                // one writeback per slot, bubbles give valid low
                wb.valid     <= em.valid;
                wb.reg_write <= em.reg_write;
                wb.wsel      <= em.wsel;
                wb.wdata     <= wdata_n;
            end else begin
                wb.valid <= 1'b0;
            end
            // sticky until reset
            if (!stall && em.valid && em.halt) begin
                halted <= 1'b1;
            end
            if (done && xfer_err) begin
                mem_err <= 1'b1;
            end
        end
    end

    // bus only runs while a load or store is held in the slot
    assert property (@(posedge CLK) disable iff (!nRST)
        apb_req.psel |-> mem_op)
        else $error("mem_access: apb transfer without a memory op in the slot");

    // address and direction held while the slave inserts waits
    // relies on exec_mem holding em under stall
    assert property (@(posedge CLK) disable iff (!nRST)
        (state == cpu_types_pkg::ACCESS && !apb_rsp.pready) |=>
            ($stable(apb_req.paddr) && $stable(apb_req.pwrite)))
        else $error("mem_access: paddr or pwrite changed during wait");

endmodule

`default_nettype wire

//--- verilog/pipe_backend.sv
// top level: execute stage, execute/memory register and memory stage
`timescale 1ns/1ps
`default_nettype none

module pipe_backend (
    input  logic                    CLK,
    input  logic                    nRST,
    input  cpu_types_pkg::ex_op_t   op_in,
    output cpu_types_pkg::apb_req_t apb_req,
    input  cpu_types_pkg::apb_rsp_t apb_rsp,
    output cpu_types_pkg::wb_t      wb,
    output cpu_types_pkg::redirect_t redirect,
    output logic                    stall,
    output logic                    halted,
    output logic                    mem_err
);

    // execute result and the registered slot
    cpu_types_pkg::ex_mem_t ex_d;
    cpu_types_pkg::ex_mem_t em_q;

    execute_stage u_execute (
        .op_in  (op_in),
        .ex_out (ex_d)
    );

    // memory stall freezes this register
    exec_mem u_exec_mem (
        .CLK  (CLK),
        .nRST (nRST),
        .hold (stall),
        .d    (ex_d),
        .q    (em_q)
    );

    mem_access u_mem (
        .CLK     (CLK),
        .nRST    (nRST),
        .em      (em_q),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .stall   (stall),
        .wb      (wb),
        .halted  (halted),
        .mem_err (mem_err)
    );

    // redirect to fetch comes straight off the slot
    assign redirect = '{valid: em_q.redirect_valid, target: em_q.redirect_target};

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
// testbench clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    input  logic rst_req,
    output logic CLK,
    output logic nRST
);

    logic por_done;

    // 8 ns period
    initial begin
        CLK = 1'b0;
        forever begin
            #4 CLK = ~CLK;
        end
    end

    // power-on reset for 16 cycles, released just after a rising edge
    initial begin
        por_done = 1'b0;
        repeat (16) @(posedge CLK);
        #1;
        por_done = 1'b1;
    end

    // later resets come from the testbench
    assign nRST = por_done && !rst_req;

endmodule

`default_nettype wire

//--- tests/apb_mem_model.sv
// apb slave memory with random wait states and an error response past the end
`timescale 1ns/1ps
`default_nettype none

module apb_mem_model (
    input  logic                    CLK,
    input  logic                    nRST,
    input  cpu_types_pkg::apb_req_t req,
    output cpu_types_pkg::apb_rsp_t rsp
);

    cpu_types_pkg::word_t mem [cpu_types_pkg::DMEM_WORDS];
    logic [1:0]           waits;
    logic [29:0]          idx;
    logic                 in_range;
    logic                 access;

    // fill word mixes every address bit
    initial begin
        for (int i = 0; i < cpu_types_pkg::DMEM_WORDS; i++) begin
            mem[i] = (32'(i) * 32'h0101_0101) ^ 32'ha5c3_0000;
        end
    end

    assign idx      = req.paddr[31:2];
    assign in_range = idx < 30'(cpu_types_pkg::DMEM_WORDS);
    assign access   = req.psel && req.penable;

    // ready once the wait count runs out
    assign rsp.pready  = access && (waits == 2'd0);
    assign rsp.prdata  = (access && in_range) ? mem[idx] : '0;
    assign rsp.pslverr = rsp.pready && !in_range;

    // 0 to 3 wait states drawn in the setup cycle
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            waits <= 2'd0;
        end else if (req.psel && !req.penable) begin
            waits <= 2'($urandom_range(3, 0));
        end else if (access && waits != 2'd0) begin
            waits <= waits - 2'd1;
        end
    end

    // write lands on the completing edge
    always @(posedge CLK) begin
        if (nRST && rsp.pready && req.pwrite && in_range) begin
            mem[idx] <= req.pwdata;
        end
    end

endmodule

`default_nettype wire

//--- tests/pipe_backend_tb.sv
// testbench top: random op stream, reference model, output checks and report
`timescale 1ns/1ps
`default_nettype none

module pipe_backend_tb;

    localparam int N_ALU = 60;
    localparam int N_MEM = 60;
    localparam int N_MIX = 80;
    localparam int N_CTL = 50;
    localparam int N_END = 8;
    localparam int TOTAL_OPS = N_ALU + N_MEM + N_MIX + N_CTL + N_END;
    // power-on reset plus the late reset of the last test
    localparam int RESET_CYCLES = 16 + 4;
    localparam int CYCLE_LIMIT = 20 * TOTAL_OPS + RESET_CYCLES;

    logic                     CLK;
    logic                     nRST;
    logic                     rst_req;
    cpu_types_pkg::ex_op_t    op_in;
    cpu_types_pkg::apb_req_t  apb_req;
    cpu_types_pkg::apb_rsp_t  apb_rsp;
    cpu_types_pkg::wb_t       wb;
    cpu_types_pkg::redirect_t redirect;
    logic                     stall;
    logic                     halted;
    logic                     mem_err;

    // reference model state and expected records in program order
    cpu_types_pkg::word_t     mem_model [cpu_types_pkg::DMEM_WORDS];
    cpu_types_pkg::wb_t       wb_q [$];
    cpu_types_pkg::redirect_t rd_q [$];
    cpu_types_pkg::wb_t       exp_wb;
    cpu_types_pkg::redirect_t exp_rd;
    int                       errors = 0;
    int                       checks = 0;
    int                       cycles = 0;
    int unsigned              seed_dummy;

    tb_clock u_clk (
        .rst_req (rst_req),
        .CLK     (CLK),
        .nRST    (nRST)
    );

    apb_mem_model u_mem (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (apb_req),
        .rsp  (apb_rsp)
    );

    pipe_backend dut (
        .CLK      (CLK),
        .nRST     (nRST),
        .op_in    (op_in),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .wb       (wb),
        .redirect (redirect),
        .stall    (stall),
        .halted   (halted),
        .mem_err  (mem_err)
    );

    // same initial contents as the slave memory
    function automatic cpu_types_pkg::word_t fill_word(input int i);
        return (32'(i) * 32'h0101_0101) ^ 32'ha5c3_0000;
    endfunction

    function automatic cpu_types_pkg::word_t alu_model(input cpu_types_pkg::alu_op_t op,
            input cpu_types_pkg::word_t a, input cpu_types_pkg::word_t b, input int sh);
        case (op)
            cpu_types_pkg::ALU_ADD: return a + b;
            cpu_types_pkg::ALU_SUB: return a - b;
            cpu_types_pkg::ALU_AND: return a & b;
            cpu_types_pkg::ALU_OR:  return a | b;
            cpu_types_pkg::ALU_XOR: return a ^ b;
            cpu_types_pkg::ALU_NOR: return ~(a | b);
            cpu_types_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            cpu_types_pkg::ALU_SLL: return b << sh;
            cpu_types_pkg::ALU_SRL: return b >> sh;
            cpu_types_pkg::ALU_LUI: return {b[15:0], 16'h0000};
            default: return '0;
        endcase
    endfunction

    // kind 0 alu, 1 load or store, 2 branch or jump, 3 load past the end
    function automatic cpu_types_pkg::ex_op_t make_op(input int kind, input int max_idx);
        cpu_types_pkg::ex_op_t op;
        int unsigned           idx;
        int unsigned           sel;
        op = '0;
        op.valid = 1'b1;
        op.pc = $urandom() & 32'hffff_fffc;
        op.rdat1 = $urandom();
        op.rdat2 = $urandom();
        op.imm = 16'($urandom());
        op.shamt = 5'($urandom());
        op.wsel = 5'($urandom_range(31, 1));
        sel = $urandom_range(4, 0);
        case (kind)
            0: begin
                op.alu_op = 4'($urandom_range(9, 0));
                op.alu_src_imm = 1'($urandom_range(1, 0));
                op.sign_ext = 1'($urandom_range(1, 0));
                op.reg_write = 1'b1;
            end
            1, 3: begin
                idx = (kind == 3) ? cpu_types_pkg::DMEM_WORDS + $urandom_range(4000, 0)
                                  : $urandom_range(max_idx, 0);
                // signed byte offset, base register makes up the rest
                op.imm = 16'(($urandom_range(63, 0) - 32) * 4);
                op.alu_op = cpu_types_pkg::ALU_ADD;
                op.alu_src_imm = 1'b1;
                op.sign_ext = 1'b1;
                op.rdat1 = (32'(idx) << 2) - {{16{op.imm[15]}}, op.imm};
                op.mem_read = (kind == 3) || sel[0];
                op.mem_write = !op.mem_read;
                op.reg_write = op.mem_read;
            end
            default: begin
                op.alu_op = cpu_types_pkg::ALU_SUB;
                // equal operands half the time so beq and bne both take
                if ($urandom_range(1, 0) == 1) begin
                    op.rdat2 = op.rdat1;
                end
                op.branch_eq = (sel == 0);
                op.branch_ne = (sel == 1);
                op.jump = (sel == 2);
                op.jump_reg = (sel == 3);
                op.jal = (sel == 4);
                op.reg_write = op.jal;
            end
        endcase
        return op;
    endfunction

    // expected writeback and redirect for one accepted op
    task automatic predict(input cpu_types_pkg::ex_op_t op);
        cpu_types_pkg::word_t     b;
        cpu_types_pkg::word_t     pc4;
        cpu_types_pkg::wb_t       e;
        cpu_types_pkg::redirect_t r;
        int unsigned              idx;
        pc4 = op.pc + 32'd4;
        if (op.alu_src_imm) begin
            b = op.sign_ext ? {{16{op.imm[15]}}, op.imm} : {16'h0000, op.imm};
        end else begin
            b = op.rdat2;
        end
        e.valid = 1'b1;
        e.reg_write = op.reg_write || op.jal;
        e.wsel = op.jal ? 5'd31 : op.wsel;
        e.wdata = op.jal ? op.pc + 32'd8 : alu_model(op.alu_op, op.rdat1, b, op.shamt);
        if (op.mem_read || op.mem_write) begin
            idx = e.wdata[31:2];
            if (idx >= cpu_types_pkg::DMEM_WORDS) begin
                // slave error, load returns zero
                e.wdata = '0;
            end else if (op.mem_write) begin
                mem_model[idx] = op.rdat2;
            end else begin
                e.wdata = mem_model[idx];
            end
        end
        wb_q.push_back(e);
        r.valid = 1'b1;
        if (op.jump_reg) begin
            r.target = op.rdat1;
        end else if (op.jump || op.jal) begin
            r.target = {pc4[31:28], 10'b0, op.imm, 2'b00};
        end else begin
            r.target = pc4 + {{14{op.imm[15]}}, op.imm, 2'b00};
        end
        if (op.jump || op.jal || op.jump_reg || (op.branch_eq && op.rdat1 == b) ||
                (op.branch_ne && op.rdat1 != b)) begin
            rd_q.push_back(r);
        end
    endtask

    // drive at edge + 1 ns, hold while stalled, return 1 ns after acceptance
    task automatic issue(input cpu_types_pkg::ex_op_t op, input logic track);
        logic stall_seen;
        op_in = op;
        do begin
            @(negedge CLK);
            stall_seen = stall;
            @(posedge CLK);
        end while (stall_seen);
        if (track) begin
            predict(op);
        end
        #1;
    endtask

    // bubbles until every expected record has been seen
    task automatic drain();
        op_in = '0;
        while (wb_q.size() != 0 || rd_q.size() != 0) begin
            @(posedge CLK);
        end
        @(posedge CLK);
        #1;
    endtask

    task automatic check_idle(input string when);
        checks++;
        assert (!wb.valid && !redirect.valid && !stall && !halted && !mem_err &&
                !apb_req.psel && !apb_req.penable)
        else begin
            $display("Mismatch at %0t: control outputs active %s", $time, when);
            errors++;
        end
    endtask

    // mode 4 mixes alu and memory ops back to back, mode 2 adds some alu ops
    task automatic run_test(input int num, input string name, input int mode, input int count);
        int start_err;
        int sub;
        start_err = errors;
        for (int n = 0; n < count; n++) begin
            case (mode)
                4: sub = $urandom_range(1, 0);
                2: sub = ($urandom_range(3, 0) == 0) ? 0 : 2;
                default: sub = mode;
            endcase
            // small address range so loads often hit earlier stores
            issue(make_op(sub, (mode == 1) ? 31 : cpu_types_pkg::DMEM_WORDS - 1), 1'b1);
            if (mode != 4 && $urandom_range(3, 0) == 0) begin
                issue('0, 1'b0);
            end
        end
        drain();
        checks++;
        assert (!mem_err && !halted)
        else begin
            $display("Mismatch at %0t: mem_err=%0b halted=%0b, expected both low",
                     $time, mem_err, halted);
            errors++;
        end
        $display("test %0d %s: %0d ops, %0d errors", num, name, count, errors - start_err);
    endtask

    task automatic end_test();
        cpu_types_pkg::ex_op_t halt_op;
        int                    start_err;
        start_err = errors;
        // out-of-range loads between good accesses
        for (int n = 0; n < N_END - 1; n++) begin
            issue(make_op(n[0] ? 3 : 1, cpu_types_pkg::DMEM_WORDS - 1), 1'b1);
        end
        drain();
        checks++;
        assert (mem_err)
        else begin
            $display("Mismatch at %0t: mem_err low after out-of-range loads", $time);
            errors++;
        end
        halt_op = '0;
        halt_op.valid = 1'b1;
        halt_op.halt = 1'b1;
        issue(halt_op, 1'b1);
        drain();
        checks++;
        assert (halted)
        else begin
            $display("Mismatch at %0t: halted low after the halt op", $time);
            errors++;
        end
        // late reset clears the sticky flags
        rst_req = 1'b1;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        check_idle("during reset");
        @(posedge CLK);
        #1;
        rst_req = 1'b0;
        @(negedge CLK);
        check_idle("after reset");
        $display("test 5 errors and end of run: %0d ops, %0d errors", N_END,
                 errors - start_err);
    endtask

    // compare outputs mid-cycle, where they are stable
    always @(negedge CLK) begin
        if (nRST) begin
            if (wb.valid) begin
                if (wb_q.size() == 0) begin
                    $display("%0t: writeback seen with no operation outstanding", $time);
                    errors++;
                end else begin
                    exp_wb = wb_q.pop_front();
                    checks++;
                    assert (wb.reg_write == exp_wb.reg_write && (!exp_wb.reg_write ||
                            (wb.wsel == exp_wb.wsel && wb.wdata == exp_wb.wdata)))
                    else begin
                        $display("Mismatch at %0t: wb we=%0b r%0d=%h, expected we=%0b r%0d=%h",
                                 $time, wb.reg_write, wb.wsel, wb.wdata,
                                 exp_wb.reg_write, exp_wb.wsel, exp_wb.wdata);
                        errors++;
                    end
                end
            end
            if (redirect.valid) begin
                if (rd_q.size() == 0) begin
                    $display("%0t: redirect seen with no taken branch outstanding", $time);
                    errors++;
                end else begin
                    exp_rd = rd_q.pop_front();
                    checks++;
                    assert (redirect.target == exp_rd.target)
                    else begin
                        $display("Mismatch at %0t: redirect to %h, expected %h",
                                 $time, redirect.target, exp_rd.target);
                        errors++;
                    end
                end
            end
            // a transfer that is not completing must hold the pipe
            if (apb_req.psel && !(apb_req.penable && apb_rsp.pready)) begin
                assert (stall)
                else begin
                    $display("Mismatch at %0t: stall low during a waiting transfer", $time);
                    errors++;
                end
            end
        end
    end

    // run length guard
    always @(posedge CLK) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        seed_dummy = $urandom(32'h110f);
        op_in = '0;
        rst_req = 1'b0;
        for (int i = 0; i < cpu_types_pkg::DMEM_WORDS; i++) begin
            mem_model[i] = fill_word(i);
        end
        @(posedge nRST);
        @(negedge CLK);
        check_idle("after power-on reset");
        @(posedge CLK);
        #1;
        run_test(1, "alu ops", 0, N_ALU);
        run_test(2, "loads and stores", 1, N_MEM);
        run_test(3, "back-pressure", 4, N_MIX);
        run_test(4, "control flow", 2, N_CTL);
        end_test();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
verilog/cpu_types_pkg.sv
verilog/alu.sv
verilog/execute_stage.sv
verilog/exec_mem.sv
verilog/mem_access.sv
verilog/pipe_backend.sv
tests/tb_clock.sv
tests/apb_mem_model.sv
tests/pipe_backend_tb.sv
